/* files.f */
execPkg.sv
alu16.sv
branchResolve.sv
instrDecode.sv
execStage.sv
execResult.sv
execTop.sv
execTb.sv

/* Makefile */
# Verilator build and run of the execute pipeline testbench

.PHONY: all run clean

all: run

obj_dir/VexecTb: files.f $(wildcard *.sv)
	verilator --binary --timing --assert -f files.f --top-module execTb

run: obj_dir/VexecTb
	@out="$$(./obj_dir/VexecTb)"; echo "$$out"; echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* execTb.sv */
// testbench for the execute pipeline
// drives execTop with directed and random operations and predicts each result
// from the instruction set rules, outputs are checked as outValid shows them
`timescale 1ns/1ps

module execTb;
   import execPkg::*;

   // one predicted output plus which of its fields the ISA defines
   typedef struct packed {
      execRes_t res;
      logic     chkResult;
      logic     chkFlags;
   } expect_t;

   logic        clk;
   logic        rstN;
   logic        inValid;
   instrWord_t  instr;
   logic [15:0] regData1;
   logic [15:0] regData2;
   logic [15:0] incPc;
   execRes_t    out;
   logic        outValid;

   int          seed = 32'he048;
   int          checks = 0;
   int          checkErrs = 0;
   int          timeoutErrs = 0;
   int          tests = 0;
   int          errAtStart = 0;
   int          checksAtStart = 0;
   string       curTest = "reset";
   expect_t     expQ[$];
   string       nameQ[$];
   logic [1:0]  inHist;
   logic [4:0]  opList [0:27];

   execTop DUT (
      .clk      (clk),
      .rstN     (rstN),
      .inValid  (inValid),
      .instr    (instr),
      .regData1 (regData1),
      .regData2 (regData2),
      .incPc    (incPc),
      .out      (out),
      .outValid (outValid)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   function automatic logic [15:0] rand16();
      int r;
      r = $random(seed);
      return r[15:0];
   endfunction

   function automatic logic [15:0] rotl(input logic [15:0] v, input logic [3:0] n);
      logic [15:0] t;
      t = v;
      repeat (n) begin
         t = {t[14:0], t[15]};
      end
      return t;
   endfunction

   function automatic logic [15:0] rotr(input logic [15:0] v, input logic [3:0] n);
      logic [15:0] t;
      t = v;
      repeat (n) begin
         t = {t[0], t[15:1]};
      end
      return t;
   endfunction

   // {overflow, sum} of a + b
   function automatic logic [16:0] addRes(input logic [15:0] a, input logic [15:0] b);
      logic [15:0] s;
      s = a + b;
      return {(a[15] == b[15]) && (s[15] != a[15]), s};
   endfunction

   // {overflow, difference} of x - y
   function automatic logic [16:0] subRes(input logic [15:0] x, input logic [15:0] y);
      logic [15:0] d;
      d = x - y;
      return {(x[15] != y[15]) && (d[15] != x[15]), d};
   endfunction

   // reference model, straight from the ISA rules
   function automatic expect_t predict(input instrWord_t w, input logic [15:0] rs,
                                       input logic [15:0] rt, input logic [15:0] pc);
      expect_t     e;
      logic [15:0] bits, s5, z5, s8, s11, r, np;
      logic [16:0] wide;
      logic [4:0]  op;
      logic [1:0]  fn;
      logic        v, flags, chkR, wr;
      bits = w;
      op   = bits[15:11];
      fn   = bits[1:0];
      s5   = {{11{bits[4]}}, bits[4:0]};
      z5   = {11'd0, bits[4:0]};
      s8   = {{8{bits[7]}}, bits[7:0]};
      s11  = {{5{bits[10]}}, bits[10:0]};
      wide = {1'b0, rs} + {1'b0, rt};
      r    = 16'd0;
      v    = 1'b0;
      chkR = 1'b1;
      case (op)
         opAddi:  {v, r} = addRes(rs, s5);
         // subtract takes the operand order reversed
         opSubi:  {v, r} = subRes(s5, rs);
         opXori:  r = rs ^ z5;
         opAndni: r = rs & ~z5;
         opRoli:  r = rotl(rs, s5[3:0]);
         opSlli:  r = rs << s5[3:0];
         opRori:  r = rotr(rs, s5[3:0]);
         opSrli:  r = rs >> s5[3:0];
         opAlu: begin
            case (fn)
               fnAdd:   {v, r} = addRes(rs, rt);
               fnSub:   {v, r} = subRes(rt, rs);
               fnXor:   r = rs ^ rt;
               default: r = rs & ~rt;
            endcase
         end
         opShift: begin
            case (fn)
               fnRol:   r = rotl(rs, rt[3:0]);
               fnSll:   r = rs << rt[3:0];
               fnRor:   r = rotr(rs, rt[3:0]);
               default: r = rs >> rt[3:0];
            endcase
         end
         // memory ops report the effective address
         opSt, opLd, opStu: r = rs + s5;
         opLbi:   r = s8;
         opSlbi:  r = {rs[7:0], bits[7:0]};
         opBtr:   r = {<<{rs}};
         opSeq:   r = {15'd0, rs == rt};
         opSlt:   r = {15'd0, $signed(rs) < $signed(rt)};
         opSle:   r = {15'd0, $signed(rs) <= $signed(rt)};
         opSco:   r = {15'd0, wide[16]};
         opJal, opJalr: r = pc;
         // branches, j and jr leave the result undefined
         default: chkR = 1'b0;
      endcase
      case (op)
         opBeqz:       np = (rs == 16'd0) ? pc + s8 : pc;
         opBnez:       np = (rs != 16'd0) ? pc + s8 : pc;
         opBltz:       np = rs[15] ? pc + s8 : pc;
         opBgez:       np = rs[15] ? pc : pc + s8;
         opJ, opJal:   np = pc + s11;
         opJr, opJalr: np = rs + s8;
         default:      np = pc;
      endcase
      flags = op inside {opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli,
                         opAlu, opShift};
      // stores, branches and plain jumps leave the register file alone
      wr    = !(op inside {opSt, opBeqz, opBnez, opBltz, opBgez, opJ, opJr});
      e               = '0;
      e.res.result    = r;
      e.res.newPc     = np;
      e.res.zero      = (r == 16'd0);
      e.res.ofl       = v;
      e.res.writesReg = wr;
      e.chkResult     = chkR;
      e.chkFlags      = flags;
      return e;
   endfunction

   // one operation on the next falling edge, inValid stays high until lowered
   task automatic issue(input logic [4:0] op, input logic [10:0] low, input logic [15:0] a,
                        input logic [15:0] b, input string name);
      instrWord_t  w;
      logic [15:0] pc;
      w  = {op, low};
      pc = rand16() & 16'hfffe;
      @(negedge clk);
      instr    = w;
      regData1 = a;
      regData2 = b;
      incPc    = pc;
      inValid  = 1'b1;
      expQ.push_back(predict(w, a, b, pc));
      nameQ.push_back(name);
   endtask

   task automatic drainOutputs();
      int waited;
      waited = 0;
      while (expQ.size() != 0 && waited < 20) begin
         @(posedge clk);
         waited++;
      end
      if (expQ.size() != 0) begin
         $display("%s: no output within timeout", curTest);
         timeoutErrs++;
         expQ.delete();
         nameQ.delete();
      end
   endtask

   task automatic startTest(input string name);
      curTest       = name;
      errAtStart    = checkErrs + timeoutErrs;
      checksAtStart = checks;
   endtask

   task automatic finishTest();
      @(negedge clk);
      inValid = 1'b0;
      drainOutputs();
      tests++;
      $display("%s: %0d checks, %0d errors", curTest, checks - checksAtStart,
               checkErrs + timeoutErrs - errAtStart);
   endtask

   // inValid as seen by the last two rising edges
   always @(posedge clk) begin
      if (!rstN) begin
         inHist <= 2'b00;
      end else begin
         inHist <= {inHist[0], inValid};
      end
   end

   always @(negedge clk) begin
      expect_t e;
      string   nm;
      // fixed latency, a strobe at edge N shows as one pulse after edge N+1
      assert (outValid === inHist[1]) else begin
         $display("%s: outValid did not follow inValid by exactly two edges", curTest);
         checkErrs++;
      end
      if (outValid === 1'b1 && expQ.size() == 0) begin
         $display("%s: output appeared with no operation pending", curTest);
         checkErrs++;
      end else if (outValid === 1'b1) begin
         e  = expQ.pop_front();
         nm = nameQ.pop_front();
         checks++;
         if (e.chkResult) begin
            assert (out.result == e.res.result) else begin
               $display("ERR %s result expected %h actual %h", nm, e.res.result, out.result);
               checkErrs++;
            end
         end
         assert (out.newPc == e.res.newPc) else begin
            $display("ERR %s newPc expected %h actual %h", nm, e.res.newPc, out.newPc);
            checkErrs++;
         end
         assert (out.writesReg == e.res.writesReg) else begin
            $display("ERR %s writesReg expected %b actual %b", nm, e.res.writesReg,
                     out.writesReg);
            checkErrs++;
         end
         if (e.chkFlags) begin
            assert (out.zero == e.res.zero) else begin
               $display("ERR %s zero expected %b actual %b", nm, e.res.zero, out.zero);
               checkErrs++;
            end
            assert (out.ofl == e.res.ofl) else begin
               $display("ERR %s ofl expected %b actual %b", nm, e.res.ofl, out.ofl);
               checkErrs++;
            end
         end
      end
   end

   initial begin
      logic [15:0] lo;
      logic [4:0]  idx;
      opList = '{opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli, opSt, opLd,
                 opStu, opSlbi, opLbi, opBtr, opAlu, opShift, opSeq, opSlt, opSle, opSco,
                 opBeqz, opBnez, opBltz, opBgez, opJ, opJr, opJal, opJalr};
      rstN     = 1'b0;
      inValid  = 1'b0;
      instr    = '0;
      regData1 = 16'd0;
      regData2 = 16'd0;
      incPc    = 16'd0;

      startTest("reset");
      repeat (10) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
      repeat (4) @(negedge clk);
      finishTest();

      startTest("arith");
      for (int k = 0; k < 6; k++) begin
         lo = rand16();
         issue(opAlu, {lo[10:2], fnAdd}, rand16(), rand16(), "add");
         issue(opAlu, {lo[10:2], fnSub}, rand16(), rand16(), "sub");
         issue(opAlu, {lo[10:2], fnXor}, rand16(), rand16(), "xor");
         issue(opAlu, {lo[10:2], fnAndn}, rand16(), rand16(), "andn");
         issue(opAddi, lo[10:0], rand16(), rand16(), "addi");
         issue(opSubi, lo[10:0], rand16(), rand16(), "subi");
         issue(opXori, lo[10:0], rand16(), rand16(), "xori");
         issue(opAndni, lo[10:0], rand16(), rand16(), "andni");
      end
      // 10 - 3 when rs = 3 and rt = 10
      issue(opAlu, {9'd0, fnSub}, 16'd3, 16'd10, "sub orientation");
      issue(opAlu, {9'd0, fnAdd}, 16'h7fff, 16'h0001, "add overflow");
      issue(opAlu, {9'd0, fnSub}, 16'h0001, 16'h8000, "sub overflow");
      issue(opAddi, 11'h001, 16'h7fff, 16'd0, "addi overflow");
      finishTest();

      startTest("shift");
      for (int k = 0; k < 6; k++) begin
         lo = rand16();
         issue(opShift, {lo[10:2], fnRol}, rand16(), rand16(), "rol");
         issue(opShift, {lo[10:2], fnSll}, rand16(), rand16(), "sll");
         issue(opShift, {lo[10:2], fnRor}, rand16(), rand16(), "ror");
         issue(opShift, {lo[10:2], fnSrl}, rand16(), rand16(), "srl");
         issue(opRoli, lo[10:0], rand16(), rand16(), "roli");
         issue(opSlli, lo[10:0], rand16(), rand16(), "slli");
         issue(opRori, lo[10:0], rand16(), rand16(), "rori");
         issue(opSrli, lo[10:0], rand16(), rand16(), "srli");
         issue(opBtr, lo[10:0], rand16(), rand16(), "btr");
         issue(opLbi, lo[10:0], rand16(), rand16(), "lbi");
         issue(opSlbi, lo[10:0], rand16(), rand16(), "slbi");
      end
      finishTest();

      startTest("setcond");
      for (int k = 0; k < 6; k++) begin
         lo = rand16();
         issue(opSeq, lo[10:0], rand16(), rand16(), "seq");
         issue(opSlt, lo[10:0], rand16(), rand16(), "slt");
         issue(opSle, lo[10:0], rand16(), rand16(), "sle");
         issue(opSco, lo[10:0], rand16(), rand16(), "sco");
         issue(opSeq, lo[10:0], lo, lo, "seq equal");
         issue(opSle, lo[10:0], lo, lo, "sle equal");
      end
      issue(opSlt, 11'd0, 16'h8000, 16'h7fff, "slt min max");
      issue(opSlt, 11'd0, 16'h7fff, 16'h8000, "slt max min");
      issue(opSle, 11'd0, 16'h8000, 16'h8000, "sle min min");
      issue(opSco, 11'd0, 16'h8000, 16'h8000, "sco min min");
      issue(opSco, 11'd0, 16'h7fff, 16'h8000, "sco max min");
      finishTest();

      startTest("branch");
      for (int k = 0; k < 3; k++) begin
         lo = rand16();
         issue(opBeqz, lo[10:0], 16'd0, rand16(), "beqz taken");
         issue(opBeqz, lo[10:0], 16'd5, rand16(), "beqz not taken");
         issue(opBnez, lo[10:0], 16'h0100, rand16(), "bnez taken");
         issue(opBnez, lo[10:0], 16'd0, rand16(), "bnez not taken");
         issue(opBltz, lo[10:0], 16'h8000, rand16(), "bltz taken");
         issue(opBltz, lo[10:0], 16'd5, rand16(), "bltz not taken");
         issue(opBgez, lo[10:0], 16'd0, rand16(), "bgez taken");
         issue(opBgez, lo[10:0], 16'hffff, rand16(), "bgez not taken");
         issue(opJ, lo[10:0], rand16(), rand16(), "j");
         issue(opJal, lo[10:0], rand16(), rand16(), "jal");
         issue(opJr, lo[10:0], rand16(), rand16(), "jr");
         issue(opJalr, lo[10:0], rand16(), rand16(), "jalr");
         issue(opLd, lo[10:0], rand16(), rand16(), "ld address");
         issue(opSt, lo[10:0], rand16(), rand16(), "st address");
         issue(opStu, lo[10:0], rand16(), rand16(), "stu address");
      end
      finishTest();

      startTest("stream");
      for (int k = 0; k < 24; k++) begin
         lo  = rand16();
         idx = lo[15:11] % 5'd28;
         issue(opList[idx], lo[10:0], rand16(), rand16(), "stream");
      end
      finishTest();

      $display("done: %0d tests, %0d checks, %0d errors", tests, checks,
               checkErrs + timeoutErrs);
      if (checkErrs + timeoutErrs == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* execTop.sv */
// top level of the execute pipeline
// decode register, combinational execute, output register
// an operation taken at edge N shows on out with outValid after edge N+1
`timescale 1ns/1ps

module execTop (
   input  logic                clk,
   input  logic                rstN,
   input  logic                inValid,
   input  execPkg::instrWord_t instr,
   input  logic [15:0]         regData1,
   input  logic [15:0]         regData2,
   input  logic [15:0]         incPc,
   output execPkg::execRes_t   out,
   output logic                outValid
);
   import execPkg::*;

   execReq_t req;
   logic     reqValid;
   execRes_t res;
   logic     resValid;

   instrDecode u_decode (
      .clk      (clk),
      .rstN     (rstN),
      .inValid  (inValid),
      .instr    (instr),
      .regData1 (regData1),
      .regData2 (regData2),
      .incPc    (incPc),
      .req      (req),
      .reqValid (reqValid)
   );

   execStage u_exec (
      .req      (req),
      .reqValid (reqValid),
      .res      (res),
      .resValid (resValid)
   );

   execResult u_result (
      .clk      (clk),
      .rstN     (rstN),
      .res      (res),
      .resValid (resValid),
      .out      (out),
      .outValid (outValid)
   );

endmodule

/* execResult.sv */
// output register of the execute pipeline
// captures the result on resValid and emits a one-cycle outValid pulse
`timescale 1ns/1ps

module execResult (
   input  logic              clk,
   input  logic              rstN,
   input  execPkg::execRes_t res,
   input  logic              resValid,
   output execPkg::execRes_t out,
   output logic              outValid
);

   always_ff @(posedge clk) begin
      if (!rstN) begin
         out      <= '0;
         outValid <= 1'b0;
      end else begin
         // pulse only follows a valid result
         outValid <= resValid;
         // last result is held between operations
         if (resValid) begin
            out <= res;
         end
      end
   end

endmodule

/* execStage.sv */
// combinational execute stage
// runs the ALU and branch logic on one request and picks the written result
// set conditions come from the ALU B - A, byte immediates and bit reverse are formed here
`timescale 1ns/1ps

module execStage (
   input  execPkg::execReq_t req,
   input  logic              reqValid,
   output execPkg::execRes_t res,
   output logic              resValid
);
   import execPkg::*;

   logic [15:0] aluY;
   logic        aluZero;
   logic        aluOfl;
   logic        aluCout;
   logic [15:0] newPc;
   logic        isLess;
   logic        setBit;
   logic [15:0] reversed;
   logic [15:0] byteImm;
   logic [15:0] result;

   alu16 u_alu (
      .opA  (req.opA),
      .opB  (req.opB),
      .op   (req.aluOp),
      .y    (aluY),
      .zero (aluZero),
      .ofl  (aluOfl),
      .cout (aluCout)
   );

   // jr and jalr targets are the alu sum
   branchResolve u_branch (
      .kind    (req.brKind),
      .opA     (req.opA),
      .imm     (req.imm),
      .incPc   (req.incPc),
      .jumpReg (aluY),
      .newPc   (newPc)
   );

   // sign of the true difference, corrected by overflow
   assign isLess = aluY[15] ^ aluOfl;

   always_comb begin
      case (req.setCond)
         condEq:  setBit = aluZero;
         condLt:  setBit = isLess;
         condLe:  setBit = aluZero | isLess;
         default: setBit = aluCout;
      endcase
   end

   always_comb begin
      for (int i = 0; i < 16; i++) begin
         reversed[i] = req.opA[15 - i];
      end
   end

   // opA is zero for lbi, so only the sign-extended byte remains
   assign byteImm = {req.opA[7:0], 8'd0} | req.imm;

   always_comb begin
      case (req.resSel)
         resSet:     result = {15'd0, setBit};
         resReverse: result = reversed;
         resByteImm: result = byteImm;
         resLink:    result = req.incPc;
         resAddr:    result = aluY;
         default:    result = aluY;
      endcase
   end

   assign res.result    = result;
   assign res.newPc     = newPc;
   assign res.zero      = aluZero;
   assign res.ofl       = aluOfl;
   assign res.writesReg = req.writesReg;

   // no state here, the strobe moves with its request
   assign resValid = reqValid;

endmodule

/* instrDecode.sv */
// decode stage of the execute pipeline
// turns one instruction word plus its register operands into an execReq_t
// the request is registered once per inValid strobe, reqValid follows a cycle later
`timescale 1ns/1ps

module instrDecode (
   input  logic               clk,
   input  logic               rstN,
   input  logic               inValid,
   input  execPkg::instrWord_t instr,
   input  logic [15:0]        regData1,
   input  logic [15:0]        regData2,
   input  logic [15:0]        incPc,
   output execPkg::execReq_t  req,
   output logic               reqValid
);
   import execPkg::*;

   logic [4:0]  opcode;
   logic [1:0]  func;
   logic [7:0]  imm8;
   logic [10:0] disp11;
   logic [15:0] sext5, zext5, sext8, zext8, sext11;
   execReq_t    nxt;

   // opcode and func sit at the same place in both views
   assign opcode = instr.rFmt.opcode;
   assign func   = instr.rFmt.func;
   // long immediates span the rd and imm fields of the i view
   assign imm8   = {instr.iFmt.rd, instr.iFmt.imm};
   assign disp11 = {instr.iFmt.rs, instr.iFmt.rd, instr.iFmt.imm};

   assign sext5  = {{11{instr.iFmt.imm[4]}}, instr.iFmt.imm};
   assign zext5  = {11'd0, instr.iFmt.imm};
   assign sext8  = {{8{imm8[7]}}, imm8};
   assign zext8  = {8'd0, imm8};
   assign sext11 = {{5{disp11[10]}}, disp11};

   always_comb begin
      // defaults: rs on A, rt on B, no write, fall through to incPc
      nxt           = '0;
      nxt.opA       = regData1;
      nxt.opB       = regData2;
      nxt.imm       = sext5;
      nxt.incPc     = incPc;
      nxt.aluOp     = aluAdd;
      nxt.resSel    = resAlu;
      nxt.setCond   = condEq;
      nxt.brKind    = brNone;
      nxt.writesReg = 1'b0;
      case (opcode)
         // subi gives imm - rs since the alu does B - A
         opAddi, opSubi, opRoli, opSlli, opRori, opSrli: begin
            nxt.opB       = sext5;
            nxt.writesReg = 1'b1;
            case (opcode)
               opAddi:  nxt.aluOp = aluAdd;
               opSubi:  nxt.aluOp = aluSub;
               opRoli:  nxt.aluOp = aluRol;
               opSlli:  nxt.aluOp = aluSll;
               opRori:  nxt.aluOp = aluRor;
               default: nxt.aluOp = aluSrl;
            endcase
         end
         opXori, opAndni: begin
            nxt.opB       = zext5;
            nxt.aluOp     = (opcode == opXori) ? aluXor : aluAndn;
            nxt.writesReg = 1'b1;
         end
         // memory ops only produce the address rs + imm
         opSt, opLd, opStu: begin
            nxt.opB       = sext5;
            nxt.resSel    = resAddr;
            nxt.writesReg = (opcode != opSt);
         end
         // lbi ors the byte onto zero, slbi onto rs << 8
         opLbi, opSlbi: begin
            nxt.opA       = (opcode == opLbi) ? 16'd0 : regData1;
            nxt.imm       = (opcode == opLbi) ? sext8 : zext8;
            nxt.resSel    = resByteImm;
            nxt.writesReg = 1'b1;
         end
         opBtr: begin
            nxt.resSel    = resReverse;
            nxt.writesReg = 1'b1;
         end
         opAlu: begin
            nxt.writesReg = 1'b1;
            case (func)
               fnAdd:   nxt.aluOp = aluAdd;
               fnSub:   nxt.aluOp = aluSub;
               fnXor:   nxt.aluOp = aluXor;
               default: nxt.aluOp = aluAndn;
            endcase
         end
         opShift: begin
            nxt.writesReg = 1'b1;
            case (func)
               fnRol:   nxt.aluOp = aluRol;
               fnSll:   nxt.aluOp = aluSll;
               fnRor:   nxt.aluOp = aluRor;
               default: nxt.aluOp = aluSrl;
            endcase
         end
         // compares swap so that B - A is rs - rt
         opSeq, opSlt, opSle: begin
            nxt.opA       = regData2;
            nxt.opB       = regData1;
            nxt.aluOp     = aluSub;
            nxt.resSel    = resSet;
            nxt.writesReg = 1'b1;
            case (opcode)
               opSeq:   nxt.setCond = condEq;
               opSlt:   nxt.setCond = condLt;
               default: nxt.setCond = condLe;
            endcase
         end
         opSco: begin
            nxt.resSel    = resSet;
            nxt.setCond   = condCarry;
            nxt.writesReg = 1'b1;
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            nxt.opB = sext8;
            nxt.imm = sext8;
            case (opcode)
               opBeqz:  nxt.brKind = brEqz;
               opBnez:  nxt.brKind = brNez;
               opBltz:  nxt.brKind = brLtz;
               default: nxt.brKind = brGez;
            endcase
         end
         opJ, opJal: begin
            nxt.imm       = sext11;
            nxt.brKind    = brJumpRel;
            nxt.resSel    = (opcode == opJal) ? resLink : resAlu;
            nxt.writesReg = (opcode == opJal);
         end
         // register jumps reuse the alu sum rs + imm as target
         opJr, opJalr: begin
            nxt.opB       = sext8;
            nxt.imm       = sext8;
            nxt.brKind    = brJumpReg;
            nxt.resSel    = (opcode == opJalr) ? resLink : resAlu;
            nxt.writesReg = (opcode == opJalr);
         end
         default: begin
            // halt, nop and unused codes flow through with no effect
            nxt.writesReg = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         req      <= '0;
         reqValid <= 1'b0;
      end else begin
         reqValid <= inValid;
         if (inValid) begin
            req <= nxt;
         end
      end
   end

endmodule

/* branchResolve.sv */
// next PC selection for branches and jumps
// the relative target is incPc + imm, register jumps take the ALU sum
`timescale 1ns/1ps

module branchResolve (
   input  execPkg::brKind_t kind,
   input  logic [15:0]      opA,
   input  logic [15:0]      imm,
   input  logic [15:0]      incPc,
   input  logic [15:0]      jumpReg,
   output logic [15:0]      newPc
);
   import execPkg::*;

   logic [15:0] relTarget;
   logic        isZero;
   logic        isNeg;

   assign relTarget = incPc + imm;

   // branch conditions look at rs only
   assign isZero = (opA == 16'd0);
   assign isNeg  = opA[15];

   always_comb begin
      case (kind)
         brEqz:     newPc = isZero ? relTarget : incPc;
         brNez:     newPc = isZero ? incPc : relTarget;
         brLtz:     newPc = isNeg ? relTarget : incPc;
         brGez:     newPc = isNeg ? incPc : relTarget;
         brJumpRel: newPc = relTarget;
         brJumpReg: newPc = jumpReg;
         default:   newPc = incPc;
      endcase
   end

endmodule

/* alu16.sv */
// 16-bit ALU of the execute stage
// add and subtract share one adder, subtract computes opB - opA
// rotates and shifts move opA by the low four bits of opB
`timescale 1ns/1ps

module alu16 (
   input  logic [15:0]     opA,
   input  logic [15:0]     opB,
   input  execPkg::aluOp_t op,
   output logic [15:0]     y,
   output logic            zero,
   output logic            ofl,
   output logic            cout
);
   import execPkg::*;

   logic        isSub;
   logic        isArith;
   logic [15:0] aIn;
   logic [16:0] sum;
   logic [3:0]  amt;
   logic [31:0] rolWide;
   logic [31:0] rorWide;

   assign isSub   = (op == aluSub);
   assign isArith = (op == aluAdd) || (op == aluSub);

   // subtract: invert A and feed the carry in
   assign aIn = isSub ? ~opA : opA;
   assign sum = {1'b0, opB} + {1'b0, aIn} + {16'd0, isSub};

   assign amt = opB[3:0];
   // rotate through a doubled copy of opA
   assign rolWide = {opA, opA} << amt;
   assign rorWide = {opA, opA} >> amt;

   always_comb begin
      case (op)
         aluAdd, aluSub: y = sum[15:0];
         aluXor:         y = opA ^ opB;
         aluAndn:        y = opA & ~opB;
         aluRol:         y = rolWide[31:16];
         aluSll:         y = opA << amt;
         aluRor:         y = rorWide[15:0];
         default:        y = opA >> amt;
      endcase
   end

   assign cout = sum[16];
   assign zero = (y == 16'd0);

   // signed overflow, both adder inputs agree in sign and the sum does not
   assign ofl = isArith && (aIn[15] == opB[15]) && (sum[15] != opB[15]);

endmodule

/* execPkg.sv */
// shared definitions for the execute pipeline of the 16-bit teaching processor
// opcodes, function codes, control enums, the instruction union and the stage structs
// modules import this package wherever they need a name from it
package execPkg;

   // major opcodes, instruction bits [15:11]
   localparam logic [4:0] opAddi  = 5'b01000;
   localparam logic [4:0] opSubi  = 5'b01001;
   localparam logic [4:0] opXori  = 5'b01010;
   localparam logic [4:0] opAndni = 5'b01011;
   localparam logic [4:0] opRoli  = 5'b10100;
   localparam logic [4:0] opSlli  = 5'b10101;
   localparam logic [4:0] opRori  = 5'b10110;
   localparam logic [4:0] opSrli  = 5'b10111;
   localparam logic [4:0] opSt    = 5'b10000;
   localparam logic [4:0] opLd    = 5'b10001;
   localparam logic [4:0] opStu   = 5'b10011;
   localparam logic [4:0] opSlbi  = 5'b10010;
   localparam logic [4:0] opLbi   = 5'b11000;
   localparam logic [4:0] opBtr   = 5'b11001;
   localparam logic [4:0] opAlu   = 5'b11011;
   localparam logic [4:0] opShift = 5'b11010;
   localparam logic [4:0] opSeq   = 5'b11100;
   localparam logic [4:0] opSlt   = 5'b11101;
   localparam logic [4:0] opSle   = 5'b11110;
   localparam logic [4:0] opSco   = 5'b11111;
   localparam logic [4:0] opBeqz  = 5'b01100;
   localparam logic [4:0] opBnez  = 5'b01101;
   localparam logic [4:0] opBltz  = 5'b01110;
   localparam logic [4:0] opBgez  = 5'b01111;
   localparam logic [4:0] opJ     = 5'b00100;
   localparam logic [4:0] opJr    = 5'b00101;
   localparam logic [4:0] opJal   = 5'b00110;
   localparam logic [4:0] opJalr  = 5'b00111;

   // function codes of the register-format alu group
   localparam logic [1:0] fnAdd  = 2'b00;
   localparam logic [1:0] fnSub  = 2'b01;
   localparam logic [1:0] fnXor  = 2'b10;
   localparam logic [1:0] fnAndn = 2'b11;

   // function codes of the register-format shift group
   localparam logic [1:0] fnRol = 2'b00;
   localparam logic [1:0] fnSll = 2'b01;
   localparam logic [1:0] fnRor = 2'b10;
   localparam logic [1:0] fnSrl = 2'b11;

   typedef enum logic [2:0] {
      aluAdd, aluSub, aluXor, aluAndn, aluRol, aluSll, aluRor, aluSrl
   } aluOp_t;

   // where the written result comes from
   typedef enum logic [2:0] {
      resAlu, resSet, resReverse, resByteImm, resLink, resAddr
   } resSel_t;

   typedef enum logic [1:0] {
      condEq, condLt, condLe, condCarry
   } setCond_t;

   typedef enum logic [2:0] {
      brNone, brEqz, brNez, brLtz, brGez, brJumpRel, brJumpReg
   } brKind_t;

   // register format: opcode rs rt rd func
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } rFmt_t;

   // immediate format, the low 8 or 11 bits double as the long immediates
   typedef struct packed {
      logic [4:0] opcode;
      logic [2:0] rs;
      logic [2:0] rd;
      logic [4:0] imm;
   } iFmt_t;

   typedef union packed {
      rFmt_t rFmt;
      iFmt_t iFmt;
   } instrWord_t;

   // decoded request held between the decode and execute stages
   typedef struct packed {
      logic [15:0] opA;
      logic [15:0] opB;
      logic [15:0] imm;
      logic [15:0] incPc;
      aluOp_t      aluOp;
      resSel_t     resSel;
      setCond_t    setCond;
      brKind_t     brKind;
      logic        writesReg;
   } execReq_t;

   typedef struct packed {
      logic [15:0] result;
      logic [15:0] newPc;
      logic        zero;
      logic        ofl;
      logic        writesReg;
   } execRes_t;

endpackage
